/* project.f */
hw/axi_mem_pkg.sv
hw/burst_beat_counter.sv
hw/sram_port_arbiter.sv
hw/sram_bank.sv
hw/axi_write_fsm.sv
hw/axi_sram_write_top.sv
verification/axi_write_assertions.sv
verification/tb_clock_gen.sv
verification/tb_axi_sram_write.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f project.f --top-module tb_axi_sram_write \
	--Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/tb_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

if echo "$output" | grep -qF "Simulation passed"; then
	echo "RUN OK"
	exit 0
fi
echo "RUN FAILED"
exit 1

/* verification/tb_axi_sram_write.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_axi_sram_write;
	import axi_mem_pkg::*;

	localparam logic [31:0] SEED = 32'he6c6_8596;
	localparam int TIMEOUT = 200;

	logic                  clk;
	logic                  rst_n;
	aw_req_t               aw_i;
	logic                  aw_valid_i;
	logic                  aw_ready_o;
	w_beat_t               w_i;
	logic                  w_valid_i;
	logic                  w_ready_o;
	b_resp_t               b_o;
	logic                  b_valid_o;
	logic                  b_ready_i;
	logic                  rd_req_i;
	logic [MEM_ADDR_W-1:0] rd_addr_i;
	logic [AXI_DATA_W-1:0] rd_data_o;
	logic                  rd_valid_o;

	logic [AXI_DATA_W-1:0] ref_mem [int];          // Reference memory, one word per entry.
	b_resp_t               exp_b [$];
	logic [31:0]           rnd_state;
	logic [AXI_DATA_W-1:0] rd_exp;
	bit                    rd_pend;
	bit                    aw_hs;
	bit                    w_hs;
	bit                    b_hs;
	bit                    noise_en;
	bit                    drop_en;
	bit                    bp_en;
	bit                    fill_en;
	int                    err_cnt;

	tb_clock_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

	axi_sram_write_top dut (
		.clk(clk), .rst_n(rst_n),
		.aw_i(aw_i), .aw_valid_i(aw_valid_i), .aw_ready_o(aw_ready_o),
		.w_i(w_i), .w_valid_i(w_valid_i), .w_ready_o(w_ready_o),
		.b_o(b_o), .b_valid_o(b_valid_o), .b_ready_i(b_ready_i),
		.rd_req_i(rd_req_i), .rd_addr_i(rd_addr_i),
		.rd_data_o(rd_data_o), .rd_valid_o(rd_valid_o)
	);

	bind axi_write_fsm axi_write_assertions u_fsm_sva (
		.clk(clk), .rst_n(rst_n), .state_i(state_q), .b_i(b_o), .b_valid_i(b_valid_o),
		.b_ready_i(b_ready_i), .w_valid_i(w_valid_i), .w_ready_i(w_ready_o), .grant_i(grant_i)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] rand32();
		rnd_state = lcg_next(rnd_state);
		return {rnd_state[15:0], rnd_state[31:16]};  // High bits are the better ones.
	endfunction

	function automatic logic [AXI_DATA_W-1:0] fill_word(input logic [MEM_ADDR_W-1:0] a);
		return {16'hc0de, 6'd0, a, 6'h3f, ~a, 16'h5a5a};
	endfunction

	function automatic aw_req_t rand_aw(input int len);
		aw_req_t a;
		a.id   = AXI_ID_W'(rand32());
		a.addr = rand32();
		a.len  = 8'(len);
		a.size = 3'd3;
		a.user = AXI_USER_W'(rand32());
		return a;
	endfunction

	function automatic void model_write(input logic [MEM_ADDR_W-1:0] a, input w_beat_t w);
		logic [AXI_DATA_W-1:0] word;
		word = ref_mem.exists(int'(a)) ? ref_mem[int'(a)] : '0;
		for (int b = 0; b < AXI_STRB_W; b++) begin
			if (w.strb[b])
				word[8*b +: 8] = w.data[8*b +: 8];
		end
		ref_mem[int'(a)] = word;
	endfunction

	task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
		input string what);
		if (got !== exp) begin
			err_cnt++;
			$display("[ERROR] %0t ns: %s mismatch, got %0h, expected %0h", $time, what, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic give_up(input string what);
		$display("Timeout: the %s handshake never happened within %0d cycles", what, TIMEOUT);
		$display("Simulation failed");
		$fatal(1);
	endtask

	// Samples at the falling edge, returns just after the next rising edge.
	task automatic next_cycle();
		@(negedge clk);
		aw_hs = aw_valid_i && aw_ready_o;
		w_hs  = w_valid_i && w_ready_o;
		b_hs  = b_valid_o && b_ready_i;
		check_value(rd_valid_o, rd_pend, "rd_valid_o");
		if (rd_pend)
			check_value(rd_data_o, rd_exp, "rd_data_o");
		if (rd_req_i)
			check_value(w_ready_o, 1'b0, "w_ready_o during read");
		rd_pend = rd_req_i;
		if (rd_req_i)
			rd_exp = ref_mem[int'(rd_addr_i)];
		@(posedge clk);
		#1;
		if (noise_en) begin
			rd_req_i  = (rand32() % 4) == 0;
			rd_addr_i = MEM_ADDR_W'(rand32());
		end
	endtask

	task automatic read_back(input logic [MEM_ADDR_W-1:0] base, input int n);
		for (int i = 0; i < n; i++) begin
			rd_req_i  = 1'b1;
			rd_addr_i = MEM_ADDR_W'(base + i);
			next_cycle();
		end
		rd_req_i = 1'b0;
		next_cycle();
	endtask

	// ------------------------------------------------------------
	// One burst from AW to B, optionally offering the next AW
	// ------------------------------------------------------------
	task automatic do_burst(input aw_req_t aw, input bit bad, input bit pre_acc,
		input bit chain, input aw_req_t next_aw);
		w_beat_t               beats [$];
		w_beat_t               beat;
		b_resp_t               exp_resp;
		logic [MEM_ADDR_W-1:0] base;
		int                    n;
		int                    k;
		int                    idle;
		bit                    aw_done;
		bit                    done;
		base = aw.addr[3 +: MEM_ADDR_W];
		n    = int'(aw.len) + (bad ? 2 : 1);        // A bad burst needs one error beat.
		for (int i = 0; i < n; i++) begin
			beat.data = fill_en ? fill_word(MEM_ADDR_W'(base + i)) : {rand32(), rand32()};
			beat.strb = fill_en ? '1 : AXI_STRB_W'(rand32());
			beat.last = bad ? (i == n - 1) : (i == int'(aw.len));
			beats.push_back(beat);
		end
		exp_resp.id   = aw.id;
		exp_resp.resp = bad ? RESP_SLVERR : RESP_OKAY;
		exp_resp.user = aw.user;
		exp_b.push_back(exp_resp);
		aw_done = pre_acc;
		k       = 0;
		idle    = 0;
		done    = 0;
		while (!done) begin
			aw_valid_i = !aw_done || (chain && k == n);
			aw_i       = aw_done ? next_aw : aw;
			w_valid_i  = (k < n) && !(drop_en && (rand32() % 4) == 0);
			w_i        = (k < n) ? beats[k] : '0;
			b_ready_i  = !(bp_en && (rand32() % 2) == 0);
			next_cycle();
			if (w_hs) begin
				if (k <= int'(aw.len))
					model_write(MEM_ADDR_W'(base + k), beats[k]);
				k++;
			end
			check_value(b_valid_o, (k == n) && !b_hs, "b_valid_o");
			if (b_valid_o)
				check_value(b_o, exp_b[0], "B payload");
			if (b_hs) begin
				check_value(aw_hs, chain, "AW handshake with B");
				void'(exp_b.pop_front());
				done = 1;
			end else if (aw_hs) begin
				check_value(aw_done, 1'b0, "repeated AW handshake");
				aw_done = 1;
			end
			idle = (aw_hs || w_hs || b_hs) ? 0 : idle + 1;
			if (idle >= TIMEOUT)
				give_up(!aw_done ? "AW" : ((k < n) ? "W" : "B"));
		end
		aw_valid_i = 1'b0;
		w_valid_i  = 1'b0;
		b_ready_i  = 1'b0;
	endtask

	initial begin
		aw_req_t aw;
		aw_req_t aw2;
		bit      bad;
		aw_i       = '0;
		aw_valid_i = 1'b0;
		w_i        = '0;
		w_valid_i  = 1'b0;
		b_ready_i  = 1'b0;
		rd_req_i   = 1'b0;
		rd_addr_i  = '0;
		rnd_state  = SEED;
		rd_pend    = 0;
		noise_en   = 0;
		drop_en    = 0;
		bp_en      = 0;
		fill_en    = 0;
		err_cnt    = 0;
		for (int c = 0; rst_n !== 1'b1; c++) begin
			if (c == TIMEOUT) begin
				$display("Reset was never released");
				$display("Simulation failed");
				$fatal(1);
			end
			@(posedge clk);
		end
		#1;
		@(negedge clk);
		check_value(aw_ready_o, 1'b1, "aw_ready_o after reset");
		check_value(w_ready_o, 1'b0, "w_ready_o after reset");
		check_value(b_valid_o, 1'b0, "b_valid_o after reset");
		check_value(rd_valid_o, 1'b0, "rd_valid_o after reset");
		@(posedge clk);
		#1;

		fill_en = 1;                                   // Every word gets a known value first.
		for (int i = 0; i < MEM_DEPTH / 16; i++) begin
			aw = rand_aw(15);
			aw.addr[3 +: MEM_ADDR_W] = MEM_ADDR_W'(16 * i);
			do_burst(aw, 0, 0, 0, aw);
		end
		fill_en = 0;
		repeat (20) begin
			aw = rand_aw(0);
			do_burst(aw, 0, 0, 0, aw);
			read_back(aw.addr[3 +: MEM_ADDR_W], 1);
		end
		drop_en = 1;
		for (int i = 0; i < 20; i++) begin
			aw = rand_aw(int'(rand32() % 15) + 1);
			if (i == 0) begin
				aw.addr[3 +: MEM_ADDR_W] = 10'h3fa;  // Wraps past the top word.
				aw.len                   = 8'd15;
			end
			do_burst(aw, 0, 0, 0, aw);
			read_back(aw.addr[3 +: MEM_ADDR_W], int'(aw.len) + 1);
		end
		repeat (10) begin
			aw = rand_aw(int'(rand32() % 16));
			do_burst(aw, 1, 0, 0, aw);
			read_back(aw.addr[3 +: MEM_ADDR_W], int'(aw.len) + 2);
		end
		noise_en = 1;
		repeat (20) begin
			aw  = rand_aw(int'(rand32() % 16));
			bad = (rand32() % 4) == 0;
			do_burst(aw, bad, 0, 0, aw);
			read_back(aw.addr[3 +: MEM_ADDR_W], int'(aw.len) + 2);
		end
		bp_en = 1;
		repeat (10) begin
			aw  = rand_aw(int'(rand32() % 16));
			aw2 = rand_aw(int'(rand32() % 16));
			do_burst(aw, 0, 0, 1, aw2);
			do_burst(aw2, 0, 1, 0, aw2);
			read_back(aw.addr[3 +: MEM_ADDR_W], int'(aw.len) + 1);
			read_back(aw2.addr[3 +: MEM_ADDR_W], int'(aw2.len) + 1);
		end

		if (err_cnt == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
	output logic clk_o,
	output logic rst_n_o
);
	initial begin
		clk_o = 1'b0;
		forever #5 clk_o = ~clk_o;                // 10 ns period.
	end

	initial begin
		rst_n_o = 1'b0;
		repeat (8) @(posedge clk_o);
		#1 rst_n_o = 1'b1;                        // Released with the stimulus skew.
	end

endmodule

`default_nettype wire

/* verification/axi_write_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module axi_write_assertions (
	input logic                  clk,
	input logic                  rst_n,
	input axi_mem_pkg::wr_state_e state_i,
	input axi_mem_pkg::b_resp_t  b_i,
	input logic                  b_valid_i,
	input logic                  b_ready_i,
	input logic                  w_valid_i,
	input logic                  w_ready_i,
	input logic                  grant_i
);
	import axi_mem_pkg::*;

	// ------------------------------------------------------------
	// Write channel handshake rules
	// ------------------------------------------------------------
	b_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(b_valid_i && !b_ready_i) |=> (b_valid_i && $stable(b_i)))
		else $error("B channel changed before its handshake");

	w_needs_grant: assert property (@(posedge clk) disable iff (!rst_n)
		!grant_i |-> !w_ready_i)
		else $error("w_ready high while the SRAM is not granted");

	// The response state never takes data.
	no_w_in_resp: assert property (@(posedge clk) disable iff (!rst_n)
		(state_i == RESP) |-> !(w_valid_i && w_ready_i))
		else $error("W handshake while waiting on B");

endmodule

`default_nettype wire

/* hw/axi_sram_write_top.sv */
`timescale 1ns/10ps
`default_nettype none

module axi_sram_write_top (
	input  logic                               clk,
	input  logic                               rst_n,
	input  axi_mem_pkg::aw_req_t               aw_i,
	input  logic                               aw_valid_i,
	output logic                               aw_ready_o,
	input  axi_mem_pkg::w_beat_t               w_i,
	input  logic                               w_valid_i,
	output logic                               w_ready_o,
	output axi_mem_pkg::b_resp_t               b_o,
	output logic                               b_valid_o,
	input  logic                               b_ready_i,
	input  logic                               rd_req_i,
	input  logic [axi_mem_pkg::MEM_ADDR_W-1:0] rd_addr_i,
	output logic [axi_mem_pkg::AXI_DATA_W-1:0] rd_data_o,
	output logic                               rd_valid_o
);
	import axi_mem_pkg::*;

	mem_req_t              wr_req;
	logic                  wr_valid;
	logic                  grant;
	logic                  cnt_load;
	logic                  cnt_step;
	logic [MEM_ADDR_W-1:0] base_addr;
	logic [BEAT_CNT_W-1:0] beat_cnt;
	logic [MEM_ADDR_W-1:0] word_addr;
	mem_req_t              mem_req;
	logic [AXI_DATA_W-1:0] q;

	axi_write_fsm u_fsm (
		.clk         (clk),
		.rst_n       (rst_n),
		.aw_i        (aw_i),
		.aw_valid_i  (aw_valid_i),
		.aw_ready_o  (aw_ready_o),
		.w_i         (w_i),
		.w_valid_i   (w_valid_i),
		.w_ready_o   (w_ready_o),
		.b_o         (b_o),
		.b_valid_o   (b_valid_o),
		.b_ready_i   (b_ready_i),
		.wr_o        (wr_req),
		.wr_valid_o  (wr_valid),
		.grant_i     (grant),
		.cnt_load_o  (cnt_load),
		.cnt_step_o  (cnt_step),
		.base_addr_o (base_addr),
		.beat_cnt_i  (beat_cnt),
		.word_addr_i (word_addr)
	);

	burst_beat_counter u_cnt (
		.clk         (clk),
		.rst_n       (rst_n),
		.load_i      (cnt_load),
		.step_i      (cnt_step),
		.base_addr_i (base_addr),
		.beat_cnt_o  (beat_cnt),
		.word_addr_o (word_addr)
	);

	sram_port_arbiter u_arb (
		.clk        (clk),
		.rst_n      (rst_n),
		.rd_req_i   (rd_req_i),
		.rd_addr_i  (rd_addr_i),
		.wr_i       (wr_req),
		.wr_valid_i (wr_valid),
		.grant_o    (grant),
		.mem_o      (mem_req),
		.q_i        (q),
		.rd_data_o  (rd_data_o),
		.rd_valid_o (rd_valid_o)
	);

	sram_bank u_sram (
		.clk   (clk),
		.mem_i (mem_req),
		.q_o   (q)
	);

endmodule

`default_nettype wire

/* hw/axi_write_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module axi_write_fsm (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  axi_mem_pkg::aw_req_t                   aw_i,
	input  logic                                   aw_valid_i,
	output logic                                   aw_ready_o,
	input  axi_mem_pkg::w_beat_t                   w_i,
	input  logic                                   w_valid_i,
	output logic                                   w_ready_o,
	output axi_mem_pkg::b_resp_t                   b_o,
	output logic                                   b_valid_o,
	input  logic                                   b_ready_i,
	output axi_mem_pkg::mem_req_t                  wr_o,
	output logic                                   wr_valid_o,
	input  logic                                   grant_i,
	output logic                                   cnt_load_o,
	output logic                                   cnt_step_o,
	output logic [axi_mem_pkg::MEM_ADDR_W-1:0]     base_addr_o,
	input  logic [axi_mem_pkg::BEAT_CNT_W-1:0]     beat_cnt_i,
	input  logic [axi_mem_pkg::MEM_ADDR_W-1:0]     word_addr_i
);
	import axi_mem_pkg::*;

	wr_state_e  state_q;
	wr_state_e  state_d;
	logic [1:0] resp_q;
	logic [1:0] resp_d;
	aw_req_t    aw_q;
	logic       aw_hs;
	logic       w_hs;
	logic       beat_hs;
	logic       last_beat;

	// ------------------------------------------------------------
	// Handshakes
	// ------------------------------------------------------------
	assign aw_ready_o = (state_q == IDLE) || ((state_q == RESP) && b_ready_i);

	always_comb begin
		case (state_q)
			IDLE:                w_ready_o = grant_i & aw_valid_i;  // First beat rides with AW.
			BURST, STALL, ERROR: w_ready_o = grant_i;
			default:             w_ready_o = 1'b0;
		endcase
	end

	assign aw_hs   = aw_valid_i & aw_ready_o;
	assign w_hs    = w_valid_i & w_ready_o;
	assign beat_hs = w_hs & (state_q != ERROR);   // Error beat is dropped.

	// Beat 0 is judged on the live AW, later beats on the captured length.
	assign last_beat = (state_q == IDLE) ? (aw_i.len == 8'd0) :
		(beat_cnt_i == BEAT_CNT_W'(aw_q.len));

	// ------------------------------------------------------------
	// Counter and memory request
	// ------------------------------------------------------------
	assign base_addr_o = aw_i.addr[3 +: MEM_ADDR_W];
	assign cnt_load_o  = aw_hs;
	assign cnt_step_o  = beat_hs;

	assign wr_valid_o = beat_hs;
	assign wr_o.we    = 1'b1;
	assign wr_o.addr  = (state_q == IDLE) ? base_addr_o : word_addr_i;
	assign wr_o.data  = w_i.data;
	assign wr_o.be    = w_i.strb;

	assign b_valid_o = (state_q == RESP);
	assign b_o.id    = aw_q.id;
	assign b_o.resp  = resp_q;
	assign b_o.user  = aw_q.user;

	// ------------------------------------------------------------
	// Next state
	// ------------------------------------------------------------
	always_comb begin
		state_d = state_q;
		resp_d  = resp_q;
		case (state_q)
			IDLE: begin
				if (aw_hs)
					state_d = w_hs ? BURST : STALL;
			end
			BURST, STALL: begin
				state_d = w_hs ? BURST : STALL;
			end
			ERROR: begin
				if (w_hs) begin
					state_d = RESP;
					resp_d  = RESP_SLVERR;
				end
			end
			RESP: begin
				if (b_ready_i)
					state_d = aw_valid_i ? STALL : IDLE;  // Back-to-back burst.
			end
			default: state_d = IDLE;
		endcase
		if (beat_hs && last_beat) begin
			state_d = w_i.last ? RESP : ERROR;
			resp_d  = RESP_OKAY;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= IDLE;
			resp_q  <= RESP_OKAY;
		end else begin
			state_q <= state_d;
			resp_q  <= resp_d;
		end
	end

	always_ff @(posedge clk) begin
		if (aw_hs)
			aw_q <= aw_i;                         // Size is kept but not acted on.
	end

endmodule

`default_nettype wire

/* hw/sram_bank.sv */
`timescale 1ns/10ps
`default_nettype none

module sram_bank (
	input  logic                               clk,
	input  axi_mem_pkg::mem_req_t              mem_i,
	output logic [axi_mem_pkg::AXI_DATA_W-1:0] q_o
);
	import axi_mem_pkg::*;

	logic [AXI_DATA_W-1:0] mem [MEM_DEPTH];

	// ------------------------------------------------------------
	// Single port: a cycle either writes or reads
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (mem_i.we) begin
			for (int b = 0; b < AXI_STRB_W; b++) begin
				if (mem_i.be[b])
					mem[mem_i.addr][8*b +: 8] <= mem_i.data[8*b +: 8];
			end
		end else begin
			q_o <= mem[mem_i.addr];               // Registered read.
		end
	end

endmodule

`default_nettype wire

/* hw/sram_port_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module sram_port_arbiter (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               rd_req_i,
	input  logic [axi_mem_pkg::MEM_ADDR_W-1:0] rd_addr_i,
	input  axi_mem_pkg::mem_req_t              wr_i,
	input  logic                               wr_valid_i,
	output logic                               grant_o,
	output axi_mem_pkg::mem_req_t              mem_o,
	input  logic [axi_mem_pkg::AXI_DATA_W-1:0] q_i,
	output logic [axi_mem_pkg::AXI_DATA_W-1:0] rd_data_o,
	output logic                               rd_valid_o
);
	import axi_mem_pkg::*;

	logic rd_pend_q;

	assign grant_o = ~rd_req_i;                   // Reads always win.

	always_comb begin
		if (rd_req_i) begin
			mem_o.we   = 1'b0;
			mem_o.addr = rd_addr_i;
			mem_o.data = '0;
			mem_o.be   = '0;
		end else begin
			mem_o      = wr_i;
			mem_o.we   = wr_i.we & wr_valid_i;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rd_pend_q <= 1'b0;
		else
			rd_pend_q <= rd_req_i;
	end

	assign rd_valid_o = rd_pend_q;
	assign rd_data_o  = rd_pend_q ? q_i : '0;

endmodule

`default_nettype wire

/* hw/burst_beat_counter.sv */
`timescale 1ns/10ps
`default_nettype none

module burst_beat_counter (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               load_i,
	input  logic                               step_i,
	input  logic [axi_mem_pkg::MEM_ADDR_W-1:0] base_addr_i,
	output logic [axi_mem_pkg::BEAT_CNT_W-1:0] beat_cnt_o,
	output logic [axi_mem_pkg::MEM_ADDR_W-1:0] word_addr_o
);
	import axi_mem_pkg::*;

	logic [BEAT_CNT_W-1:0] cnt_q;
	logic [MEM_ADDR_W-1:0] base_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt_q <= '0;
		end else if (load_i) begin
			cnt_q <= step_i ? BEAT_CNT_W'(1) : '0;  // Beat 0 may go with AW.
		end else if (step_i) begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (load_i)
			base_q <= base_addr_i;
	end

	assign beat_cnt_o = cnt_q;

	// Wraps at the memory depth.
	assign word_addr_o = base_q + MEM_ADDR_W'(cnt_q);

endmodule

`default_nettype wire

/* hw/axi_mem_pkg.sv */
`default_nettype none

package axi_mem_pkg;

	// ------------------------------------------------------------
	// Widths
	// ------------------------------------------------------------
	localparam int AXI_ID_W   = 16;
	localparam int AXI_ADDR_W = 32;
	localparam int AXI_DATA_W = 64;
	localparam int AXI_USER_W = 10;
	localparam int AXI_STRB_W = AXI_DATA_W / 8;
	localparam int MEM_ADDR_W = 10;
	localparam int MEM_DEPTH  = 1 << MEM_ADDR_W;
	localparam int BEAT_CNT_W = 9;                 // One more than AWLEN.

	localparam logic [1:0] RESP_OKAY   = 2'd0;
	localparam logic [1:0] RESP_SLVERR = 2'd2;

	typedef enum logic [2:0] {
		IDLE,
		BURST,
		STALL,
		RESP,
		ERROR
	} wr_state_e;

	// ------------------------------------------------------------
	// Channel payloads
	// ------------------------------------------------------------
	typedef struct packed {
		logic [AXI_ID_W-1:0]   id;
		logic [AXI_ADDR_W-1:0] addr;
		logic [7:0]            len;
		logic [2:0]            size;
		logic [AXI_USER_W-1:0] user;
	} aw_req_t;

	typedef struct packed {
		logic [AXI_DATA_W-1:0] data;
		logic [AXI_STRB_W-1:0] strb;
		logic                  last;
	} w_beat_t;

	typedef struct packed {
		logic [AXI_ID_W-1:0]   id;
		logic [1:0]            resp;
		logic [AXI_USER_W-1:0] user;
	} b_resp_t;

	typedef struct packed {
		logic                  we;
		logic [MEM_ADDR_W-1:0] addr;
		logic [AXI_DATA_W-1:0] data;
		logic [AXI_STRB_W-1:0] be;                 // One bit per byte lane.
	} mem_req_t;

endpackage

`default_nettype wire
